/* rtl/fpResultPkg.sv */
`default_nettype none

package fpResultPkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int FLEN   = 64;  // result word, wide enough for double
    localparam int NEMAX  = 11;  // widest exponent field
    localparam int NFMAX  = 52;  // widest fraction field
    localparam int NUMFMT = 3;

    ////////////////////
    // encodings
    ////////////////////

    // result format, also the lane index at the top level
    typedef enum logic [1:0] {
        FMT_SINGLE = 2'd0,
        FMT_DOUBLE = 2'd1,
        FMT_HALF   = 2'd2
    } fmtT;

    typedef enum logic [2:0] {
        RNE = 3'd0,  // nearest, ties to even
        RZ  = 3'd1,  // toward zero
        RD  = 3'd2,  // toward -inf
        RU  = 3'd3,  // toward +inf
        RMM = 3'd4   // nearest, ties to max magnitude
    } roundModeT;

    // result class, listed in priority order
    typedef enum logic [2:0] {
        SEL_XNAN,
        SEL_YNAN,
        SEL_INVALID,
        SEL_OVF,
        SEL_UNF,
        SEL_NORM
    } selT;

    typedef logic [FLEN-1:0] resultT;

    ////////////////////
    // per format fields
    ////////////////////

    // indexed by fmtT: single, double, half
    localparam int FMT_NE [NUMFMT] = '{8, 11, 5};
    localparam int FMT_NF [NUMFMT] = '{23, 52, 10};

endpackage

`default_nettype wire

/* rtl/resultBusIf.sv */
`default_nettype none

// one decoded beat, held for a cycle between decoder and drain
interface resultBusIf;
    import fpResultPkg::*;

    logic             valid;
    fmtT              fmt;
    selT              sel;
    logic             sign;
    logic             ofMax;   // overflow gives max finite instead of inf
    logic             unfLsb;  // lsb of the underflow result
    logic [NEMAX-1:0] exp;
    logic [NFMAX-1:0] frac;
    logic [NFMAX-1:0] xFrac;   // operand fractions for nan payloads
    logic [NFMAX-1:0] yFrac;

    modport source (
        output valid, fmt, sel, sign, ofMax, unfLsb,
        output exp, frac, xFrac, yFrac
    );

    // lanes only need the fields, not the handshake
    modport lane (
        input sel, sign, ofMax, unfLsb,
        input exp, frac, xFrac, yFrac
    );

    modport drain (
        input valid, fmt
    );

endinterface

`default_nettype wire

/* rtl/resultDecode.sv */
`default_nettype none

module resultDecode (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               inValid,
    input  logic                               xNaN,
    input  logic                               yNaN,
    input  logic                               invalid,
    input  logic                               overflow,
    input  logic                               infIn,
    input  logic                               divByZero,
    input  logic                               expNeg,     // exponent went below range
    input  logic                               plus1,      // rounding added one
    input  logic                               resSign,
    input  fpResultPkg::fmtT                   fmt,
    input  fpResultPkg::roundModeT             roundMode,
    input  logic [fpResultPkg::NEMAX-1:0]      resExp,
    input  logic [fpResultPkg::NFMAX-1:0]      resFrac,
    input  logic [fpResultPkg::NFMAX-1:0]      xFrac,
    input  logic [fpResultPkg::NFMAX-1:0]      yFrac,
    resultBusIf.source                         bus
);
    import fpResultPkg::*;

    selT  selNext;
    logic ofMaxNext;
    logic unfLsbNext;

    ////////////////////
    // classify the beat
    ////////////////////

    // first true class wins, nan from x beats everything
    always_comb begin
        if (xNaN) begin
            selNext = SEL_XNAN;
        end else if (yNaN) begin
            selNext = SEL_YNAN;
        end else if (invalid) begin
            selNext = SEL_INVALID;
        end else if (overflow | divByZero | infIn) begin
            selNext = SEL_OVF;
        end else if (expNeg) begin
            selNext = SEL_UNF;
        end else begin
            selNext = SEL_NORM;
        end
    end

    // rounding toward zero magnitude saturates at max finite,
    // but a true infinity or a divide by zero always stays infinite
    assign ofMaxNext = ~infIn & ~divByZero &
                       ((roundMode == RZ) |
                        ((roundMode == RD) & ~resSign) |
                        ((roundMode == RU) & resSign));

    // directed modes keep the rounded-up lsb, nearest modes flush to zero
    assign unfLsbNext = plus1 & ((roundMode == RD) | (roundMode == RU));

    ////////////////////
    // beat register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            bus.fmt    <= fmt;
            bus.sel    <= selNext;
            bus.sign   <= resSign;
            bus.ofMax  <= ofMaxNext;
            bus.unfLsb <= unfLsbNext;
            bus.exp    <= resExp;
            bus.frac   <= resFrac;
            bus.xFrac  <= xFrac;   // payloads kept even when unused
            bus.yFrac  <= yFrac;
        end
    end

endmodule

`default_nettype wire

/* rtl/formatLane.sv */
`default_nettype none

module formatLane #(
    parameter int NE = 8,
    parameter int NF = 23
) (
    resultBusIf.lane              bus,
    output fpResultPkg::resultT   candidate
);
    import fpResultPkg::*;

    localparam int Len = 1 + NE + NF;

    // ones above the format, zero mask for double
    localparam resultT PadMask = ~((resultT'(1) << Len) - 1);

    logic [Len-1:0] word;
    logic [Len-1:0] xNanRes;
    logic [Len-1:0] yNanRes;
    logic [Len-1:0] invalidRes;
    logic [Len-1:0] ofRes;
    logic [Len-1:0] ufRes;
    logic [Len-1:0] normRes;

    ////////////////////
    // nan results
    ////////////////////

    // quiet bit forced, payload is the operand fraction after its first bit
    assign xNanRes = {1'b0, {NE{1'b1}}, 1'b1, bus.xFrac[NFMAX-2 -: NF-1]};
    assign yNanRes = {1'b0, {NE{1'b1}}, 1'b1, bus.yFrac[NFMAX-2 -: NF-1]};
    assign invalidRes = {1'b0, {NE{1'b1}}, 1'b1, {(NF-1){1'b0}}};  // canonical nan

    ////////////////////
    // range results
    ////////////////////

    assign ofRes = bus.ofMax ? {bus.sign, {(NE-1){1'b1}}, 1'b0, {NF{1'b1}}}  // max finite
                             : {bus.sign, {NE{1'b1}}, {NF{1'b0}}};           // signed inf

    assign ufRes = {bus.sign, {(Len-2){1'b0}}, bus.unfLsb};  // zero or min subnormal

    // narrow formats take the low exponent bits and the top fraction bits
    assign normRes = {bus.sign, bus.exp[NE-1:0], bus.frac[NFMAX-1 -: NF]};

    always_comb begin
        case (bus.sel)
            SEL_XNAN:    word = xNanRes;
            SEL_YNAN:    word = yNanRes;
            SEL_INVALID: word = invalidRes;
            SEL_OVF:     word = ofRes;
            SEL_UNF:     word = ufRes;
            default:     word = normRes;
        endcase
    end

    // nan-box into the full register width
    assign candidate = PadMask | resultT'(word);

endmodule

`default_nettype wire

/* rtl/resultDrain.sv */
`default_nettype none

module resultDrain #(
    parameter int Depth      = 4,
    parameter int OutCredits = 2
) (
    input  logic                  clk,
    input  logic                  rstN,
    resultBusIf.drain             bus,
    input  fpResultPkg::resultT   candidates [fpResultPkg::NUMFMT],
    input  logic                  outCredit,   // downstream returns one credit
    output logic                  outValid,
    output fpResultPkg::resultT   outRes,
    output logic                  inCredit     // one fifo slot freed
);
    import fpResultPkg::*;

    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);
    localparam int CredW = $clog2(OutCredits + 1);

    resultT           mem [Depth];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [CntW-1:0]  count;
    logic [CredW-1:0] credits;
    logic             push;
    logic             pop;

    // upstream credits keep the fifo from overflowing
    assign push = bus.valid;
    assign pop  = (count != '0) && (credits != '0);

    ////////////////////
    // fifo storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= candidates[bus.fmt];  // lane for this beat's format
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // idle or push and pop together
            endcase
        end
    end

    ////////////////////
    // output credits
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            credits <= CredW'(OutCredits);
        end else begin
            case ({pop, outCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // send and return cancel
            endcase
        end
    end

    // registered output, one result per pop
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            inCredit <= 1'b0;
        end else begin
            outValid <= pop;
            inCredit <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            outRes <= mem[rdPtr];
        end
    end

endmodule

`default_nettype wire

/* rtl/fpResultSelect.sv */
`default_nettype none

module fpResultSelect #(
    parameter int Depth      = 4,  // fifo entries and initial upstream credits
    parameter int OutCredits = 2
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               inValid,
    input  logic                               xNaN,
    input  logic                               yNaN,
    input  logic                               invalid,
    input  logic                               overflow,
    input  logic                               infIn,
    input  logic                               divByZero,
    input  logic                               expNeg,
    input  logic                               plus1,
    input  logic                               resSign,
    input  fpResultPkg::fmtT                   fmt,
    input  fpResultPkg::roundModeT             roundMode,
    input  logic [fpResultPkg::NEMAX-1:0]      resExp,
    input  logic [fpResultPkg::NFMAX-1:0]      resFrac,
    input  logic [fpResultPkg::NFMAX-1:0]      xFrac,
    input  logic [fpResultPkg::NFMAX-1:0]      yFrac,
    input  logic                               outCredit,
    output logic                               outValid,
    output fpResultPkg::resultT                outRes,
    output logic                               inCredit
);
    import fpResultPkg::*;

    resultBusIf resBus ();

    resultT candidates [NUMFMT];  // one boxed word per format

    resultDecode decode_i (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .xNaN      (xNaN),
        .yNaN      (yNaN),
        .invalid   (invalid),
        .overflow  (overflow),
        .infIn     (infIn),
        .divByZero (divByZero),
        .expNeg    (expNeg),
        .plus1     (plus1),
        .resSign   (resSign),
        .fmt       (fmt),
        .roundMode (roundMode),
        .resExp    (resExp),
        .resFrac   (resFrac),
        .xFrac     (xFrac),
        .yFrac     (yFrac),
        .bus       (resBus)
    );

    // lane i builds the result for format code i
    for (genvar i = 0; i < NUMFMT; i++) begin : genLane
        formatLane #(
            .NE (FMT_NE[i]),
            .NF (FMT_NF[i])
        ) lane_i (
            .bus       (resBus),
            .candidate (candidates[i])
        );
    end

    resultDrain #(
        .Depth      (Depth),
        .OutCredits (OutCredits)
    ) drain_i (
        .clk        (clk),
        .rstN       (rstN),
        .bus        (resBus),
        .candidates (candidates),
        .outCredit  (outCredit),
        .outValid   (outValid),
        .outRes     (outRes),
        .inCredit   (inCredit)
    );

endmodule

`default_nettype wire

/* include/resultChecks.svh */
`ifndef RESULT_CHECKS_SVH
`define RESULT_CHECKS_SVH

int valueErrors = 0;  // wrong result words
int countErrors = 0;  // wrong counts

task automatic compareResult(input string name, input fpResultPkg::resultT got,
                             input fpResultPkg::resultT expected);
    if (got !== expected) begin
        valueErrors++;
        $display("error at %0t: outRes in %s is %h, expected %h", $time, name, got,
                 expected);
    end
endtask

task automatic compareCount(input string name, input int got, input int expected);
    if (got != expected) begin
        countErrors++;
        $display("error at %0t: %s count is %0d, expected %0d", $time, name, got, expected);
    end
endtask

////////////////////
// reference model
////////////////////

// pack sign, low exponent bits and top fraction bits, then box with ones
function automatic fpResultPkg::resultT packFields(input fpResultPkg::fmtT fmt,
        input logic sign, input logic [10:0] exp, input logic [51:0] frac);
    int ne;
    int nf;
    fpResultPkg::resultT word;
    ne = fpResultPkg::FMT_NE[fmt];
    nf = fpResultPkg::FMT_NF[fmt];
    word = (fpResultPkg::resultT'(sign) << (ne + nf)) |
           ((fpResultPkg::resultT'(exp) & ((64'd1 << ne) - 64'd1)) << nf) |
           (fpResultPkg::resultT'(frac) >> (52 - nf));
    if (ne + nf + 1 < 64) begin
        word = word | ~((64'd1 << (ne + nf + 1)) - 64'd1);
    end
    return word;
endfunction

function automatic fpResultPkg::resultT modelResult(input fpResultPkg::fmtT fmt,
        input fpResultPkg::roundModeT rm, input logic xNaN, input logic yNaN,
        input logic invalid, input logic overflow, input logic infIn, input logic divByZero,
        input logic expNeg, input logic plus1, input logic sign, input logic [10:0] exp,
        input logic [51:0] frac, input logic [51:0] xFrac, input logic [51:0] yFrac);
    logic ofMax;
    logic unfLsb;
    ofMax = 1'b0;
    unfLsb = 1'b0;
    case (rm)
        fpResultPkg::RZ: ofMax = 1'b1;
        fpResultPkg::RD: begin
            ofMax = ~sign;  // positive overflow rounds down to max finite
            unfLsb = plus1;
        end
        fpResultPkg::RU: begin
            ofMax = sign;   // negative overflow rounds up to max finite
            unfLsb = plus1;
        end
        default: ofMax = 1'b0;  // nearest modes
    endcase
    if (infIn | divByZero) begin
        ofMax = 1'b0;  // exact infinity stays infinite
    end
    if (xNaN) return packFields(fmt, 1'b0, '1, {1'b1, xFrac[50:0]});
    if (yNaN) return packFields(fmt, 1'b0, '1, {1'b1, yFrac[50:0]});
    if (invalid) return packFields(fmt, 1'b0, '1, {1'b1, 51'd0});
    if (overflow | infIn | divByZero) begin
        return ofMax ? packFields(fmt, sign, 11'h7fe, '1) : packFields(fmt, sign, '1, '0);
    end
    if (expNeg) begin
        return packFields(fmt, sign, '0, '0) | 64'(unfLsb);
    end
    return packFields(fmt, sign, exp, frac);
endfunction

`endif

/* verification/fpResultSelectTb.sv */
`default_nettype none

module fpResultSelectTb;
    timeunit 1ns;
    timeprecision 1ps;

    import fpResultPkg::*;

    localparam int Depth      = 4;
    localparam int OutCredits = 2;
    localparam int Timeout    = 500;  // cycles allowed for any single wait

    logic clk = 1'b0;
    logic rstN;
    logic inValid, xNaN, yNaN, invalid, overflow, infIn, divByZero, expNeg, plus1, resSign;
    fmtT fmt;
    roundModeT roundMode;
    logic [NEMAX-1:0] resExp;
    logic [NFMAX-1:0] resFrac, xFrac, yFrac;
    logic outCredit, outValid, inCredit;
    resultT outRes;

    resultT expQ[$];           // expected words in send order
    resultT gotQ[$];           // words seen on the output
    int beatsSent = 0;
    int creditsReturned = 0;   // inCredit pulses seen
    int creditsToReturn = 0;   // manual output credits requested
    int returnedOut = 0;       // manual output credits already pulsed
    bit autoReturn = 1'b1;     // give back one credit per received result
    int timeoutErrors = 0;
    logic [31:0] lcgState = 32'h9b22_542f;

    `include "resultChecks.svh"

    fpResultSelect #(.Depth(Depth), .OutCredits(OutCredits)) dut_i (
        .clk(clk), .rstN(rstN), .inValid(inValid), .xNaN(xNaN), .yNaN(yNaN),
        .invalid(invalid), .overflow(overflow), .infIn(infIn), .divByZero(divByZero),
        .expNeg(expNeg), .plus1(plus1), .resSign(resSign), .fmt(fmt),
        .roundMode(roundMode), .resExp(resExp), .resFrac(resFrac), .xFrac(xFrac),
        .yFrac(yFrac), .outCredit(outCredit), .outValid(outValid), .outRes(outRes),
        .inCredit(inCredit)
    );

    always #2 clk = ~clk;

    ////////////////////
    // output side
    ////////////////////

    always @(posedge clk) begin
        if (rstN && outValid) gotQ.push_back(outRes);
        if (rstN && inCredit) creditsReturned <= creditsReturned + 1;
    end

    // auto returns take priority over manual ones
    always @(posedge clk) begin
        if (autoReturn && outValid && rstN) begin
            outCredit <= 1'b1;
        end else if (returnedOut < creditsToReturn) begin
            outCredit <= 1'b1;
            returnedOut <= returnedOut + 1;
        end else begin
            outCredit <= 1'b0;
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [51:0] randFrac();
        logic [63:0] r;
        r = {nextRand(), nextRand()};
        return r[51:0];
    endfunction

    task automatic returnCredits(input int n);
        creditsToReturn += n;
    endtask

    ////////////////////
    // beat driver
    ////////////////////

    task automatic sendBeat(input fmtT f, input roundModeT rm, input logic xn, yn, inv,
                            ovf, inf, dbz, eneg, p1, sign);
        int waitCycles;
        logic [31:0] r;
        logic [51:0] fr, xf, yf;
        waitCycles = 0;
        while ((beatsSent - creditsReturned) >= Depth && waitCycles < Timeout) begin
            @(negedge clk);
            waitCycles++;
        end
        if (waitCycles >= Timeout) begin
            timeoutErrors++;
            $display("timeout: no input credit came back within %0d cycles", Timeout);
        end
        r  = nextRand();
        fr = randFrac();
        xf = randFrac();
        yf = randFrac();
        @(posedge clk);
        inValid <= 1'b1;
        fmt <= f;
        roundMode <= rm;
        xNaN <= xn;
        yNaN <= yn;
        invalid <= inv;
        overflow <= ovf;
        infIn <= inf;
        divByZero <= dbz;
        expNeg <= eneg;
        plus1 <= p1;
        resSign <= sign;
        resExp <= r[10:0];
        resFrac <= fr;
        xFrac <= xf;
        yFrac <= yf;
        beatsSent++;
        expQ.push_back(modelResult(f, rm, xn, yn, inv, ovf, inf, dbz, eneg, p1, sign,
                                   r[10:0], fr, xf, yf));
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    // waits for n results and checks them against the model in order
    task automatic collectResults(input string name, input int n);
        int waitCycles;
        waitCycles = 0;
        while (gotQ.size() < n && waitCycles < Timeout) begin
            @(negedge clk);
            waitCycles++;
        end
        if (waitCycles >= Timeout) begin
            timeoutErrors++;
            $display("timeout: %s did not deliver all results", name);
        end
        compareCount(name, gotQ.size(), n);
        while (gotQ.size() > 0 && expQ.size() > 0) begin
            compareResult(name, gotQ.pop_front(), expQ.pop_front());
        end
        gotQ.delete();
        expQ.delete();
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic normalPacking();
        logic [31:0] r;
        for (int f = 0; f < NUMFMT; f++) begin
            for (int k = 0; k < 4; k++) begin
                r = nextRand();
                sendBeat(fmtT'(f), roundModeT'(r[3:1] % 5), 0, 0, 0, 0, 0, 0, 0, 0, r[0]);
            end
        end
        collectResults("normal", 12);
    endtask

    task automatic nanPriority();
        for (int f = 0; f < NUMFMT; f++) begin
            for (int extra = 0; extra < 2; extra++) begin  // also with ovf and expNeg
                sendBeat(fmtT'(f), RNE, 1, 1, 1, extra[0], 0, 0, extra[0], 0, 1);
                sendBeat(fmtT'(f), RNE, 0, 1, 1, extra[0], 0, 0, extra[0], 0, 1);
                sendBeat(fmtT'(f), RNE, 0, 0, 1, extra[0], 0, 0, extra[0], 0, 1);
            end
        end
        collectResults("nan priority", 18);
    endtask

    task automatic overflowRounding();
        for (int f = 0; f < NUMFMT; f++) begin
            for (int rm = 0; rm < 5; rm++) begin
                sendBeat(fmtT'(f), roundModeT'(rm), 0, 0, 0, 1, 0, 0, 0, 0, 0);
                sendBeat(fmtT'(f), roundModeT'(rm), 0, 0, 0, 1, 0, 0, 0, 0, 1);
                sendBeat(fmtT'(f), roundModeT'(rm), 0, 0, 0, 0, 1, 0, 0, 0, rm[0]);
                sendBeat(fmtT'(f), roundModeT'(rm), 0, 0, 0, 0, 0, 1, 0, 0, ~rm[0]);
            end
        end
        collectResults("overflow", 60);
    endtask

    task automatic underflowRounding();
        for (int f = 0; f < NUMFMT; f++) begin
            for (int rm = 0; rm < 5; rm++) begin
                sendBeat(fmtT'(f), roundModeT'(rm), 0, 0, 0, 0, 0, 0, 1, 0, rm[0]);
                sendBeat(fmtT'(f), roundModeT'(rm), 0, 0, 0, 0, 0, 0, 1, 1, rm[1]);
            end
        end
        collectResults("underflow", 30);
    endtask

    task automatic creditBackPressure();
        autoReturn = 1'b0;
        sendBeat(FMT_DOUBLE, RNE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        sendBeat(FMT_SINGLE, RNE, 0, 0, 0, 0, 0, 0, 0, 0, 1);
        collectResults("drain credits", OutCredits);  // spends every output credit
        for (int k = 0; k < Depth; k++) begin
            sendBeat(fmtT'(k % NUMFMT), RZ, 0, 0, 0, k == 1, 0, 0, k == 2, 0, k[0]);
        end
        repeat (20) @(negedge clk);
        compareCount("held results", gotQ.size(), 0);
        compareCount("beats in flight", beatsSent - creditsReturned, Depth);
        returnCredits(OutCredits);
        autoReturn = 1'b1;
        collectResults("released", Depth);
    endtask

    initial begin
        rstN = 1'b0;
        inValid = 1'b0;
        {xNaN, yNaN, invalid, overflow, infIn, divByZero, expNeg, plus1, resSign} = '0;
        fmt = FMT_SINGLE;
        roundMode = RNE;
        resExp = '0;
        resFrac = '0;
        xFrac = '0;
        yFrac = '0;
        outCredit = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        normalPacking();
        nanPriority();
        overflowRounding();
        underflowRounding();
        creditBackPressure();
        repeat (20) @(negedge clk);
        compareCount("extra results", gotQ.size(), 0);
        compareCount("input credits", creditsReturned, beatsSent);
        $display("value errors %0d, count errors %0d, timeouts %0d",
                 valueErrors, countErrors, timeoutErrors);
        if (valueErrors + countErrors + timeoutErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fpResultSelect.f */
+incdir+include
rtl/fpResultPkg.sv
rtl/resultBusIf.sv
rtl/resultDecode.sv
rtl/formatLane.sv
rtl/resultDrain.sv
rtl/fpResultSelect.sv
verification/fpResultSelectTb.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f fpResultSelect.f \
    --top-module fpResultSelectTb -Mdir obj_dir

output=$(./obj_dir/VfpResultSelectTb)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
